// ==== Bender.yml ====
package:
  name: exe_branch

sources:
  - verilog/drac_pkg.sv
  - verilog/branch_res_if.sv
  - verilog/branch_unit.sv
  - verilog/branch_resolve.sv
  - verilog/exe_branch_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/exe_branch_assert.sv
      - dv/tb_exe_branch.sv

// ==== dv/exe_branch_assert.sv ====
// Branch execution stage output assertions
// Bound onto the top level, checks the exclusive outputs and reset state

`timescale 1ns/10ps

module exe_branch_assert (
    input logic            clk_i,
    input logic            rst_i,
    input logic            wb_valid_i,      // Top level wb_valid_o
    input logic            redirect_i,      // Top level redirect_o
    input drac_pkg::addr_t redirect_pc_i,
    input logic            ex_valid_i
);
    import drac_pkg::*;

    // ------------------------------------------------------------------
    // Output relations
    // ------------------------------------------------------------------

    // Exception suppresses redirect and writeback
    a_ex_alone : assert property (@(posedge clk_i) disable iff (rst_i)
        ex_valid_i |-> !(redirect_i || wb_valid_i))
        else $error("exception raised together with redirect or writeback");

    // Redirect never goes to a misaligned PC
    a_redirect_aligned : assert property (@(posedge clk_i) disable iff (rst_i)
        redirect_i |-> (redirect_pc_i[ALIGN_LSB-1:0] == '0))
        else $error("redirect to a PC off the instruction boundary");

    // All strobes quiet one cycle after reset
    a_quiet_after_reset : assert property (@(posedge clk_i)
        rst_i |=> (!wb_valid_i && !redirect_i && !ex_valid_i))
        else $error("valid output high in the cycle after reset");

endmodule

bind exe_branch_top exe_branch_assert u_branch_assert (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .wb_valid_i    (wb_valid_o),
    .redirect_i    (redirect_o),
    .redirect_pc_i (redirect_pc_o),
    .ex_valid_i    (ex_valid_o)
);

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset source
// Free-running clock, reset held high for a fixed number of cycles

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD       = 10.0,     // ns
    parameter int  RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o     // Synchronous, active high
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2.0) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;   // Released just after the edge, like other stimulus
    end
endmodule

// ==== dv/tb_exe_branch.sv ====
// Branch execution stage testbench
// Random control transfers from a fixed seed, checked cycle by cycle
// against a reference model of the resolve rules

`timescale 1ns/10ps

module tb_exe_branch;
    import drac_pkg::*;

    localparam int NUM_INSTR    = 2000;
    localparam int MAX_IDLE     = 64;      // Budget of valid gaps
    localparam int RESET_CYCLES = 4;
    localparam int CYCLE_LIMIT  = NUM_INSTR + MAX_IDLE + RESET_CYCLES + 32;   // 2100

    // One cycle of expected outputs
    typedef struct packed {
        logic      wb_valid;
        reg_addr_t wb_rd;
        bus64_t    wb_data;
        logic      redirect;
        addr_t     redirect_pc;
        logic      ex_valid;
        addr_t     ex_origin;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        valid;
    instr_type_t itype;
    addr_t       pc;
    bus64_t      imm;
    bus64_t      rs1;
    bus64_t      rs2;
    reg_addr_t   rd;
    logic        ptaken;
    addr_t       ptarget;

    logic        wb_valid;
    reg_addr_t   wb_rd;
    bus64_t      wb_data;
    logic        redirect;
    addr_t       redirect_pc;
    logic        ex_valid;
    addr_t       ex_origin;

    integer      seed = 2;
    int          cycle_cnt = 0;
    int          idle_used = 0;
    int          n_sent = 0;
    expect_t     exp_q[$];      // Expected outputs, one entry per cycle

    tb_clock_gen #(.PERIOD(10.0), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    exe_branch_top UUT (
        .clk_i         (clk),
        .rst_i         (rst),
        .valid_i       (valid),
        .instr_type_i  (itype),
        .pc_i          (pc),
        .imm_i         (imm),
        .rs1_data_i    (rs1),
        .rs2_data_i    (rs2),
        .rd_i          (rd),
        .pred_taken_i  (ptaken),
        .pred_target_i (ptarget),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex_valid_o    (ex_valid),
        .ex_origin_o   (ex_origin)
    );

    // ------------------------------------------------------------------
    // Timeout
    // ------------------------------------------------------------------

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("*** TEST FAILED ***");
            $fatal(1, "Cycle limit reached");
        end
    end

    // ------------------------------------------------------------------
    // Random helpers
    // ------------------------------------------------------------------

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic bus64_t rand64();
        bus64_t v;
        v[63:32] = $random(seed);
        v[31:0]  = $random(seed);
        return v;
    endfunction

    // Jump or branch destination before the taken decision
    function automatic addr_t jump_target(instr_type_t t, addr_t pc_v, bus64_t imm_v,
                                          bus64_t rs1_v);
        addr_t sum;
        sum = (t == JALR) ? rs1_v + imm_v : pc_v + imm_v;
        if (t == JAL || t == JALR)
            sum[0] = 1'b0;             // Low bit dropped for jumps
        return sum;
    endfunction

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    function automatic expect_t model_branch(logic v, instr_type_t t, addr_t pc_v,
                                             bus64_t imm_v, bus64_t a, bus64_t b,
                                             reg_addr_t rd_v, logic p_taken,
                                             addr_t p_target);
        expect_t e;
        logic    eq;
        logic    lt_u;
        logic    lt_s;
        logic    cond;
        logic    fault;
        addr_t   fall;
        addr_t   tgt;
        addr_t   actual;
        addr_t   predicted;
        e     = '0;                          // Data reads zero when its strobe is low
        eq    = (a == b);
        lt_u  = (a < b);
        lt_s  = (a[63] != b[63]) ? a[63] : lt_u;   // Negative side is smaller
        fall  = pc_v + 64'd4;
        tgt   = jump_target(t, pc_v, imm_v, a);
        predicted = p_taken ? p_target : fall;
        case (t)
            BEQ:     cond = eq;
            BNE:     cond = !eq;
            BLT:     cond = lt_s;
            BGE:     cond = !lt_s;
            BLTU:    cond = lt_u;
            BGEU:    cond = !lt_u;
            JALR:    cond = 1'b1;
            default: cond = 1'b0;            // JAL, NOP
        endcase
        actual = cond ? tgt : fall;
        fault  = cond && (actual[1:0] != 2'b00);
        if (v && t == JAL) begin
            // Link only, decode already redirected
            e.wb_valid = (rd_v != '0);
        end else if (v && t != NOP) begin
            if (fault) begin
                e.ex_valid  = 1'b1;
                e.ex_origin = actual;
            end else begin
                e.redirect = (actual != predicted);
                e.wb_valid = (t == JALR) && (rd_v != '0);
            end
            if (e.redirect)
                e.redirect_pc = actual;
        end
        if (e.wb_valid) begin
            e.wb_rd   = rd_v;
            e.wb_data = fall;
        end
        return e;
    endfunction

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    task automatic build_instr();
        int unsigned sel;
        int unsigned pmode;
        addr_t       tgt;
        bus64_t      imm_raw;
        sel = rand_below(16);
        case (sel)
            0, 1:    itype = JAL;
            2, 3, 4: itype = JALR;
            5, 6:    itype = BEQ;
            7, 8:    itype = BNE;
            9, 10:   itype = BLT;
            11:      itype = BGE;
            12, 13:  itype = BLTU;
            14:      itype = BGEU;
            default: itype = NOP;
        endcase
        pc  = rand64() & ~64'h3;                    // Fetch PCs are aligned
        rs1 = rand64();
        rs2 = rand64();
        case (rand_below(8))
            0, 1:    rs2 = rs1;                       // Equal operands
            2: begin
                rs1 = {{56{rs1[7]}}, rs1[7:0]};       // Small, sign bit may be set
                rs2 = {{56{rs2[7]}}, rs2[7:0]};
            end
            default: ;
        endcase
        imm_raw = rand64();
        imm = {{52{imm_raw[11]}}, imm_raw[11:2], 2'b00};   // Sign-extended, 4-byte step
        if (rand_below(8) == 0)
            imm[1] = 1'b1;                            // Misaligned offset
        if (itype == JALR && rand_below(4) != 0)
            rs1[1:0] = 2'b00;
        rd = (rand_below(8) == 0) ? 5'd0 : 5'(rand_below(32));
        tgt   = jump_target(itype, pc, imm, rs1);
        pmode = rand_below(4);
        ptaken  = (pmode != 1);
        ptarget = rand64();
        if (pmode == 0)
            ptarget = tgt;                            // Right target
        else if (pmode == 2)
            ptarget = tgt + 64'd4;                    // Wrong target
    endtask

    // ------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Output mismatch at cycle %0d", cycle_cnt);
        end
    endtask

    task automatic check_outputs(expect_t e);
        check_value("wb_valid_o", wb_valid, e.wb_valid);
        check_value("wb_rd_o", wb_rd, e.wb_rd);
        check_value("wb_data_o", wb_data, e.wb_data);
        check_value("redirect_o", redirect, e.redirect);
        check_value("redirect_pc_o", redirect_pc, e.redirect_pc);
        check_value("ex_valid_o", ex_valid, e.ex_valid);
        check_value("ex_origin_o", ex_origin, e.ex_origin);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        valid   = 1'b0;
        itype   = NOP;
        pc      = '0;
        imm     = '0;
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        ptaken  = 1'b0;
        ptarget = '0;

        // Quiet outputs during reset, sampled mid-cycle
        do begin
            @(negedge clk);
            check_outputs('0);
        end while (rst);

        exp_q.push_back('0);    // valid_i low at the first edge after reset
        while (n_sent < NUM_INSTR) begin
            @(posedge clk);
            #1;
            check_outputs(exp_q.pop_front());
            build_instr();
            if (idle_used < MAX_IDLE && rand_below(16) == 0) begin
                valid = 1'b0;                       // Gap, data still toggles
                idle_used++;
            end else begin
                valid = 1'b1;
                n_sent++;
            end
            exp_q.push_back(model_branch(valid, itype, pc, imm, rs1, rs2, rd,
                                         ptaken, ptarget));
        end

        // Drain the last result, then one idle cycle
        @(posedge clk);
        #1;
        check_outputs(exp_q.pop_front());
        valid = 1'b0;
        exp_q.push_back('0);
        @(posedge clk);
        #1;
        check_outputs(exp_q.pop_front());

        if (exp_q.size() != 0) begin
            $display("expected results left over at the end of the run");
            $display("*** TEST FAILED ***");
            $fatal(1, "Unchecked results");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== exe_branch_top.f ====
verilog/drac_pkg.sv
verilog/branch_res_if.sv
verilog/branch_unit.sv
verilog/branch_resolve.sv
verilog/exe_branch_top.sv
dv/tb_clock_gen.sv
dv/exe_branch_assert.sv
dv/tb_exe_branch.sv

// ==== verilog/branch_res_if.sv ====
// Evaluated branch passed from the compute block to the resolve register
// One entry per cycle at most, plain valid strobe, no back-pressure

`timescale 1ns/10ps

interface branch_res_if;
    import drac_pkg::*;

    logic        valid;         // One-cycle strobe per instruction
    instr_type_t instr_type;    // Selects link writeback in resolve
    reg_addr_t   rd;            // Link destination
    logic        taken;         // Real outcome, JAL always reads as not taken
    addr_t       next_pc;       // Target if taken, else PC+4
    bus64_t      link;          // PC+4
    logic        misaligned;    // Taken target off a 4-byte boundary
    logic        mispredict;    // next_pc differs from predicted next PC

    // Compute side
    modport unit (
        output valid, instr_type, rd, taken,
        output next_pc, link, misaligned, mispredict
    );

    // Register side
    modport resolve (
        input valid, instr_type, rd, taken,
        input next_pc, link, misaligned, mispredict
    );

endinterface

// ==== verilog/branch_resolve.sv ====
// Branch resolve register
// One register stage after the branch unit; applies output priority
// and drives link writeback, redirect and misaligned exception

`timescale 1ns/10ps

module branch_resolve (
    input  logic                clk_i,
    input  logic                rst_i,          // Synchronous, active high
    branch_res_if.resolve       res_i,          // Evaluated branch
    output logic                wb_valid_o,     // Link writeback strobe
    output drac_pkg::reg_addr_t wb_rd_o,        // Writeback destination
    output drac_pkg::bus64_t    wb_data_o,      // Link value PC+4
    output logic                redirect_o,     // Fetch redirect strobe
    output drac_pkg::addr_t     redirect_pc_o,  // Correct next PC
    output logic                ex_valid_o,     // Misaligned exception strobe
    output drac_pkg::addr_t     ex_origin_o     // Faulting target
);
    import drac_pkg::*;

    logic ex_d;
    logic redirect_d;
    logic wb_d;
    logic is_jump;      // JAL or JALR, the only types with a link

    // ------------------------------------------------------------------
    // Priority, exception first
    // ------------------------------------------------------------------

    assign is_jump = (res_i.instr_type == JAL) || (res_i.instr_type == JALR);

    // Misaligned only ever set on a taken transfer
    assign ex_d = res_i.valid && res_i.misaligned && res_i.taken;

    // Exception wins over redirect
    assign redirect_d = res_i.valid && res_i.mispredict && !ex_d;

    // JALR can write and redirect in the same cycle
    assign wb_d = res_i.valid && is_jump && (res_i.rd != '0) && !ex_d;   // x0 never written

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o    <= 1'b0;
            wb_rd_o       <= '0;
            wb_data_o     <= '0;
            redirect_o    <= 1'b0;
            redirect_pc_o <= '0;
            ex_valid_o    <= 1'b0;
            ex_origin_o   <= '0;
        end else begin
            wb_valid_o    <= wb_d;
            redirect_o    <= redirect_d;
            ex_valid_o    <= ex_d;

            // Data zeroed whenever its strobe is low
            wb_rd_o       <= wb_d       ? res_i.rd      : '0;
            wb_data_o     <= wb_d       ? res_i.link    : '0;
            redirect_pc_o <= redirect_d ? res_i.next_pc : '0;
            ex_origin_o   <= ex_d       ? res_i.next_pc : '0;  // Faulting target
        end
    end

endmodule

// ==== verilog/branch_unit.sv ====
// Branch unit, combinational part of the branch execution stage
// Evaluates condition, target, next PC, link, misalignment and mispredict
// against the front end prediction, all in the same cycle

`timescale 1ns/10ps

module branch_unit (
    input  logic                valid_i,        // Issued control transfer
    input  drac_pkg::instr_type_t instr_type_i, // JAL, JALR or conditional
    input  drac_pkg::addr_t     pc_i,           // Instruction PC
    input  drac_pkg::bus64_t    imm_i,          // Sign-extended immediate
    input  drac_pkg::bus64_t    rs1_data_i,     // Operand 1
    input  drac_pkg::bus64_t    rs2_data_i,     // Operand 2
    input  drac_pkg::reg_addr_t rd_i,           // Link destination
    input  logic                pred_taken_i,   // Front end direction
    input  drac_pkg::addr_t     pred_target_i,  // Front end target
    branch_res_if.unit          res_o           // Evaluated branch
);
    import drac_pkg::*;

    logic   equal;
    logic   less;
    logic   less_u;
    logic   is_cond;        // One of the six compare types
    logic   is_jalr;
    logic   taken;
    addr_t  target_sum;     // Raw adder output
    addr_t  target;
    addr_t  pc_plus4;
    addr_t  next_pc;
    addr_t  pred_next_pc;   // What fetch went on with

    // ------------------------------------------------------------------
    // Compares, computed once and shared by all types
    // ------------------------------------------------------------------

    assign equal  = (rs1_data_i == rs2_data_i);
    assign less   = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign less_u = (rs1_data_i < rs2_data_i);  // Differs from less when sign bits differ

    assign is_cond = (instr_type_i == BEQ)  || (instr_type_i == BNE)  ||
                     (instr_type_i == BLT)  || (instr_type_i == BGE)  ||
                     (instr_type_i == BLTU) || (instr_type_i == BGEU);
    assign is_jalr = (instr_type_i == JALR);

    // Condition select
    always_comb begin
        case (instr_type_i)
            JAL:     taken = 1'b0;      // Already redirected at decode
            JALR:    taken = 1'b1;
            BEQ:     taken = equal;
            BNE:     taken = ~equal;
            BLT:     taken = less;
            BGE:     taken = ~less;
            BLTU:    taken = less_u;
            BGEU:    taken = ~less_u;
            default: taken = 1'b0;      // NOP
        endcase
    end

    // ------------------------------------------------------------------
    // Target and next PC
    // ------------------------------------------------------------------

    // JALR adds to rs1, everything else is PC relative
    assign target_sum = is_jalr ? (rs1_data_i + imm_i) : (pc_i + imm_i);

    always_comb begin
        case (instr_type_i)
            JAL, JALR: target = {target_sum[XLEN-1:1], 1'b0};    // Bit 0 cleared
            default:   target = target_sum;
        endcase
    end

    assign pc_plus4 = pc_i + addr_t'(INSTR_BYTES);      // Fall-through and link value
    assign next_pc  = taken ? target : pc_plus4;

    // Predicted next PC as fetch saw it
    assign pred_next_pc = pred_taken_i ? pred_target_i : pc_plus4;

    // ------------------------------------------------------------------
    // Result towards the resolve register
    // ------------------------------------------------------------------

    assign res_o.valid      = valid_i;
    assign res_o.instr_type = instr_type_i;
    assign res_o.rd         = rd_i;
    assign res_o.taken      = taken;
    assign res_o.next_pc    = next_pc;
    assign res_o.link       = pc_plus4;

    // JAL never mispredicts here, decode handled it
    assign res_o.mispredict = valid_i && (is_cond || is_jalr) &&
                              (next_pc != pred_next_pc);

    // Only a taken transfer can fault, a not-taken branch just falls through
    assign res_o.misaligned = valid_i && (is_jalr || (is_cond && taken)) &&
                              (next_pc[ALIGN_LSB-1:0] != '0);

endmodule

// ==== verilog/drac_pkg.sv ====
// DRAC branch execution stage shared definitions
// Widths, instruction type encoding and common vector types

package drac_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------

    localparam int unsigned XLEN        = 64;   // Data path width
    localparam int unsigned REG_ADDR_W  = 5;    // Architectural register index width

    // No compressed instructions, so one fetch unit is 4 bytes
    localparam int unsigned INSTR_BYTES = 4;    // Fall-through step and alignment unit

    // Low PC bits that must be zero on a legal target
    localparam int unsigned ALIGN_LSB   = $clog2(INSTR_BYTES);

    // ------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------

    typedef logic [XLEN-1:0]       bus64_t;     // Operands, immediates, links
    typedef logic [XLEN-1:0]       addr_t;      // PCs and targets
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // x0..x31

    // ------------------------------------------------------------------
    // Control-transfer instruction type
    // ------------------------------------------------------------------

    // NOP sits at zero so an idle or cleared slot decodes as no branch
    typedef enum logic [3:0] {
        NOP  = 4'd0,    // Not a control transfer
        JAL  = 4'd1,    // Direct jump, resolved at decode
        JALR = 4'd2,    // Indirect jump
        BEQ  = 4'd3,    // Equal
        BNE  = 4'd4,    // Not equal
        BLT  = 4'd5,    // Signed less than
        BGE  = 4'd6,    // Signed greater or equal
        BLTU = 4'd7,    // Unsigned less than
        BGEU = 4'd8     // Unsigned greater or equal
    } instr_type_t;

    // Conditional branches share one target adder and one set of compares;
    // JAL and JALR are handled apart in the unit

endpackage

// ==== verilog/exe_branch_top.sv ====
// Branch execution stage top level
// Combinational branch unit followed by the one-cycle resolve register

`timescale 1ns/10ps

module exe_branch_top (
    input  logic                  clk_i,
    input  logic                  rst_i,          // Synchronous, active high

    // Issued instruction
    input  logic                  valid_i,
    input  drac_pkg::instr_type_t instr_type_i,
    input  drac_pkg::addr_t       pc_i,
    input  drac_pkg::bus64_t      imm_i,
    input  drac_pkg::bus64_t      rs1_data_i,
    input  drac_pkg::bus64_t      rs2_data_i,
    input  drac_pkg::reg_addr_t   rd_i,
    input  logic                  pred_taken_i,   // Prediction from fetch
    input  drac_pkg::addr_t       pred_target_i,

    // Resolved outputs, one cycle after valid_i
    output logic                  wb_valid_o,
    output drac_pkg::reg_addr_t   wb_rd_o,
    output drac_pkg::bus64_t      wb_data_o,
    output logic                  redirect_o,
    output drac_pkg::addr_t       redirect_pc_o,
    output logic                  ex_valid_o,
    output drac_pkg::addr_t       ex_origin_o
);

    branch_res_if res_if ();    // Unit to resolve

    // Evaluate in the issue cycle
    branch_unit u_unit (
        .valid_i       (valid_i),
        .instr_type_i  (instr_type_i),
        .pc_i          (pc_i),
        .imm_i         (imm_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .rd_i          (rd_i),
        .pred_taken_i  (pred_taken_i),
        .pred_target_i (pred_target_i),
        .res_o         (res_if.unit)
    );

    // Register and prioritise
    branch_resolve u_resolve (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .res_i         (res_if.resolve),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .ex_valid_o    (ex_valid_o),
        .ex_origin_o   (ex_origin_o)
    );

endmodule
